// ==== src.f ====
+incdir+design
design/bus_pkg.sv
design/periph_pkg.sv
design/bus_decoder.sv
design/dual_port_ram.sv
design/machine_timer.sv
design/plic.sv
design/uart_periph.sv
design/platform_top.sv
tests/platform_chk.sv
tests/platform_tb.sv

// ==== tests/platform_patterns.txt ====
// columns: op addr data expected, all hex
// op 1 write (expected = byte mask), 2 read, 3 button, 4 wait irq, 5 uart byte
// op 6 random ram word, 7 mtime rises, 8 write that must stall, 0 end
// ram byte lanes and fetch port
1 00000010 11223344 0000000F
1 00000010 AABBCCDD 00000005
2 00000010 00000000 11BB33DD
6 00000100 00000000 00000000
6 000003FC 00000000 00000000
6 10000004 00000000 00000000
// timer
7 20000000 00000000 00000000
1 2000000C 00000000 0000000F
1 20000008 00000000 0000000F
4 00000000 00000000 00000080
1 2000000C FFFFFFFF 0000000F
1 20000008 FFFFFFFF 0000000F
4 00000000 00000000 00000000
// uart, second write lands while busy
1 80000000 00000055 00000001
8 80000000 000000A3 00000001
5 00000000 00000000 00000055
5 00000000 00000000 000000A3
// plic with source 1 only
1 30000000 00000001 0000000F
4 00000000 00000000 00000000
3 00000000 00000000 00000000
4 00000000 00000000 00000800
2 30000004 00000000 00000001
4 00000000 00000000 00000000
2 30000004 00000000 00000000
// mask zero, then both sources
1 30000000 00000000 0000000F
3 00000000 00000000 00000000
4 00000000 00000000 00000000
1 30000000 00000003 0000000F
4 00000000 00000000 00000800
2 30000004 00000000 00000001
2 30000004 00000000 00000002
2 30000004 00000000 00000000
4 00000000 00000000 00000000
// region boundaries
1 00000FF8 CAFE0000 0000000F
1 1FFFFFFC A5A50001 0000000F
1 00000008 0BADF00D 0000000F
1 20000008 12345678 0000000F
1 7FFFFFF8 00000002 0000000F
2 1FFFFFFC 00000000 A5A50001
2 00000008 00000000 0BADF00D
2 00000FF8 00000000 CAFE0000
2 20000008 00000000 12345678
2 30000000 00000000 00000002
0 00000000 00000000 00000000

// ==== tests/platform_tb.sv ====
`timescale 1ns/1ps
`include "platform_consts.svh"

module platform_tb;

    localparam int    CLK_PERIOD = 100;
    localparam int    DRIVE_DLY  = 10;
    localparam int    BIT_NS     = `PLAT_UART_CLKS_PER_BIT * CLK_PERIOD;
    localparam int    MAX_OPS    = 64;
    localparam int    SEED       = 2;
    localparam string PAT_FILE   = "tests/platform_patterns.txt";

    // pattern opcodes
    localparam logic [31:0] OP_WRITE    = 32'd1;
    localparam logic [31:0] OP_READ     = 32'd2;
    localparam logic [31:0] OP_BUTTON   = 32'd3;
    localparam logic [31:0] OP_WAIT_IRQ = 32'd4;
    localparam logic [31:0] OP_UART     = 32'd5;
    localparam logic [31:0] OP_RAND     = 32'd6;
    localparam logic [31:0] OP_MTIME    = 32'd7;
    localparam logic [31:0] OP_STALL_WR = 32'd8;

    logic                 clk;
    logic                 arst_n_i;
    bus_pkg::bus_req_t    bus_req;
    logic [31:0]          rdata;
    logic [31:0]          fetch_addr;
    logic [31:0]          fetch_data;
    logic                 stall;
    logic [63:0]          mtime;
    periph_pkg::cpu_irq_t irq;
    logic                 btn;
    logic                 uart_tx;
    logic [31:0]          pat [0:4*MAX_OPS-1];
    int                   n_ops = 0;
    logic [7:0]           rx_q [$];   // bytes seen on the tx line
    logic [63:0]          cycle_cnt;  // rising edges since reset release

    platform_top DUT (
        .clk(clk), .arst_n_i(arst_n_i), .bus_req_i(bus_req), .rdata_o(rdata),
        .fetch_addr_i(fetch_addr), .fetch_data_o(fetch_data), .stall_o(stall),
        .mtime_o(mtime), .irq_o(irq), .btn_i(btn), .uart_tx_o(uart_tx)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // expected timer value, one step per clock after reset
    always @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 64'd1;
        end
    end

    //////////////////////////////////////////////////
    // reporting and compares
    //////////////////////////////////////////////////

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            report_failure($sformatf("** Error at %0t ns: %s got %08h, expected %08h",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_irq(input periph_pkg::cpu_irq_t got, input periph_pkg::cpu_irq_t exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error at %0t ns: irq vector %08h, expected %08h",
                                     $time, got, exp));
        end
    endtask

    task automatic check_uart(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error at %0t ns: uart byte %02h, expected %02h",
                                     $time, got, exp));
        end
    endtask

    task automatic check_mtime(input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error at %0t ns: mtime %016h, expected %016h",
                                     $time, got, exp));
        end
    endtask

    //////////////////////////////////////////////////
    // cpu side bus model
    //////////////////////////////////////////////////

    // starts and ends 10 ns after a rising edge
    task automatic bus_access(
        input  logic [3:0]  we,
        input  logic [31:0] addr,
        input  logic [31:0] wdata,
        output logic [31:0] rd,
        output logic [31:0] fd,
        output int          stalls
    );
        stalls        = 0;
        bus_req.en    = 1'b1;
        bus_req.we    = we;
        bus_req.addr  = addr;
        bus_req.wdata = wdata;
        fetch_addr    = addr;
        @(negedge clk);
        while (stall) begin  // keep the same request up
            stalls++;
            @(negedge clk);
        end
        @(posedge clk);
        #DRIVE_DLY;
        bus_req = '0;
        @(negedge clk);
        rd = rdata;          // one cycle after the taken edge
        fd = fetch_data;
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic press_button();
        btn = 1'b1;
        repeat (6) @(posedge clk);  // long enough for sync and edge detect
        #DRIVE_DLY;
        btn = 1'b0;
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic wait_irq(input periph_pkg::cpu_irq_t exp);
        for (int n = 0; n < 50 && irq !== exp; n++) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
        check_irq(irq, exp);
    endtask

    //////////////////////////////////////////////////
    // uart monitor, samples at bit centers
    //////////////////////////////////////////////////

    initial begin : uart_monitor
        logic [7:0] rx_byte;
        wait (arst_n_i === 1'b1);
        forever begin
            @(negedge uart_tx);
            #(BIT_NS/2);
            if (uart_tx !== 1'b0) report_failure("uart start bit did not stay low");
            for (int b = 0; b < 8; b++) begin
                #(BIT_NS);
                rx_byte[b] = uart_tx;
            end
            #(BIT_NS);
            if (uart_tx !== 1'b1) report_failure("uart stop bit was not high");
            rx_q.push_back(rx_byte);
        end
    end

    // stop at the first failed bound assertion
    always @(negedge clk) begin
        if (DUT.u_chk.fired_cnt != 0) report_failure("a bound assertion failed");
    end

    initial begin : watchdog
        wait (n_ops > 0);
        #(n_ops * 200 * CLK_PERIOD);
        $display("timeout: patterns did not finish within %0d cycles", n_ops * 200);
        $display("Done: errors found");
        $fatal(1, "timeout");
    end

    //////////////////////////////////////////////////
    // pattern sequencer
    //////////////////////////////////////////////////

    initial begin : main_seq
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] expv;
        logic [31:0] rd;
        logic [31:0] fd;
        logic [31:0] first_rd;
        logic [31:0] rand_word;
        int          stalls;
        int          cnt;
        void'($urandom(SEED));
        bus_req    = '0;
        fetch_addr = '0;
        btn        = 1'b0;
        arst_n_i   = 1'b0;
        $readmemh(PAT_FILE, pat);
        cnt = 0;
        while (cnt < MAX_OPS && !$isunknown(pat[4*cnt]) && pat[4*cnt] != 32'd0) begin
            cnt++;
        end
        n_ops = cnt;
        if (n_ops == 0) report_failure("pattern file is empty or missing");
        repeat (3) @(posedge clk);
        #DRIVE_DLY;
        arst_n_i = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;

        for (int i = 0; i < n_ops; i++) begin
            op   = pat[4*i];
            addr = pat[4*i+1];
            data = pat[4*i+2];
            expv = pat[4*i+3];
            case (op)
                OP_WRITE: bus_access(expv[3:0], addr, data, rd, fd, stalls);
                OP_STALL_WR: begin
                    bus_access(expv[3:0], addr, data, rd, fd, stalls);
                    if (stalls == 0) report_failure("write to a busy uart was not stalled");
                end
                OP_READ: begin
                    bus_access(4'h0, addr, 32'd0, rd, fd, stalls);
                    check_word(rd, expv, "read data");
                    if (addr[31:28] < 4'h2) check_word(fd, expv, "fetch data");
                end
                OP_RAND: begin
                    rand_word = $urandom;
                    bus_access(4'hF, addr, rand_word, rd, fd, stalls);
                    bus_access(4'h0, addr, 32'd0, rd, fd, stalls);
                    check_word(rd, rand_word, "random read data");
                    check_word(fd, rand_word, "random fetch data");
                end
                OP_MTIME: begin
                    bus_access(4'h0, addr, 32'd0, first_rd, fd, stalls);
                    bus_access(4'h0, addr, 32'd0, rd, fd, stalls);
                    if (!(rd > first_rd)) begin
                        report_failure($sformatf("** Error at %0t ns: mtime %08h not above %08h",
                                                 $time, rd, first_rd));
                    end
                    // read holds the count of its request cycle, two edges back
                    check_word(rd, cycle_cnt[31:0] - 32'd2, "mtime low read");
                    check_mtime(mtime, cycle_cnt);
                end
                OP_BUTTON: press_button();
                OP_WAIT_IRQ: wait_irq(periph_pkg::cpu_irq_t'(expv));
                OP_UART: begin
                    for (int n = 0; n < 100 && rx_q.size() == 0; n++) begin
                        @(posedge clk);
                        #DRIVE_DLY;
                    end
                    if (rx_q.size() == 0) report_failure("no uart frame arrived");
                    check_uart(rx_q.pop_front(), expv[7:0]);
                end
                default: report_failure($sformatf("unknown pattern op %0h at entry %0d", op, i));
            endcase
        end

        @(posedge clk);
        #DRIVE_DLY;
        if (DUT.u_chk.fired_cnt != 0) begin
            $display("assertion failures: %0d", DUT.u_chk.fired_cnt);
            $display("Done: errors found");
            $fatal(1, "assertions failed");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

// ==== tests/platform_chk.sv ====
`timescale 1ns/1ps
`include "platform_consts.svh"

module platform_chk (
    input logic                    clk,
    input logic                    arst_n_i,
    input logic                    ram_en,
    input logic                    rtc_en,
    input logic                    plic_en,
    input logic                    periph_en,
    input periph_pkg::cpu_irq_t    irq_o,
    input logic                    uart_tx_o,
    input periph_pkg::uart_state_e uart_state
);

    localparam logic [31:0] IRQ_USED = (32'd1 << `PLAT_MEI_BIT) | (32'd1 << `PLAT_MTI_BIT);

    int unsigned fired_cnt = 0;  // failed assertions so far

    //////////////////////////////////////////////////
    // decode and interrupt vector
    //////////////////////////////////////////////////

    a_region_onehot: assert property (@(posedge clk) disable iff (!arst_n_i)
        $onehot0({ram_en, rtc_en, plic_en, periph_en}))
    else begin
        $error("more than one region enable high");
        fired_cnt++;
    end

    a_irq_bits: assert property (@(posedge clk) disable iff (!arst_n_i)
        (32'(irq_o) & ~IRQ_USED) == 32'd0)
    else begin
        $error("irq vector has bits outside mei and mti");
        fired_cnt++;
    end

    //////////////////////////////////////////////////
    // uart line
    //////////////////////////////////////////////////

    a_tx_idle_high: assert property (@(posedge clk) disable iff (!arst_n_i)
        (uart_state == periph_pkg::UART_IDLE) |-> uart_tx_o)
    else begin
        $error("tx line low while transmitter idle");
        fired_cnt++;
    end

endmodule

bind platform_top platform_chk u_chk (
    .clk(clk), .arst_n_i(arst_n_i),
    .ram_en(ram_en), .rtc_en(rtc_en), .plic_en(plic_en), .periph_en(periph_en),
    .irq_o(irq_o), .uart_tx_o(uart_tx_o), .uart_state(u_uart.state_q)
);

// ==== design/platform_top.sv ====
`timescale 1ns/1ps
`include "platform_consts.svh"

module platform_top (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  bus_pkg::bus_req_t    bus_req_i,
    output logic [31:0]          rdata_o,
    input  logic [31:0]          fetch_addr_i,
    output logic [31:0]          fetch_data_o,
    output logic                 stall_o,
    output logic [63:0]          mtime_o,
    output periph_pkg::cpu_irq_t irq_o,
    input  logic                 btn_i,
    output logic                 uart_tx_o
);

    logic                         ram_en, rtc_en, plic_en, periph_en;
    logic [31:0]                  ram_rdata, rtc_rdata, plic_rdata, periph_rdata;
    logic                         mei, mti;
    logic [`PLAT_IRQ_SOURCES-1:0] src_req, src_ack;

    //////////////////////////////////////////////////
    // decode and memory
    //////////////////////////////////////////////////

    bus_decoder u_decoder (
        .clk(clk), .arst_n_i(arst_n_i), .req_i(bus_req_i),
        .ram_en_o(ram_en), .rtc_en_o(rtc_en), .plic_en_o(plic_en), .periph_en_o(periph_en),
        .ram_rdata_i(ram_rdata), .rtc_rdata_i(rtc_rdata),
        .plic_rdata_i(plic_rdata), .periph_rdata_i(periph_rdata),
        .rdata_o(rdata_o)
    );

    dual_port_ram u_ram (
        .clk(clk),
        .fetch_en_i(!stall_o),  // freeze the fetch word
        .fetch_addr_i(fetch_addr_i), .fetch_data_o(fetch_data_o),
        .en_i(ram_en), .req_i(bus_req_i), .rdata_o(ram_rdata)
    );

    //////////////////////////////////////////////////
    // timer, plic, peripherals
    //////////////////////////////////////////////////

    machine_timer u_timer (
        .clk(clk), .arst_n_i(arst_n_i), .en_i(rtc_en), .req_i(bus_req_i),
        .rdata_o(rtc_rdata), .mtime_o(mtime_o), .mti_o(mti)
    );

    plic u_plic (
        .clk(clk), .arst_n_i(arst_n_i), .en_i(plic_en), .req_i(bus_req_i),
        .rdata_o(plic_rdata), .src_req_i(src_req), .src_ack_o(src_ack), .mei_o(mei)
    );

    uart_periph u_uart (
        .clk(clk), .arst_n_i(arst_n_i), .en_i(periph_en), .req_i(bus_req_i),
        .rdata_o(periph_rdata), .stall_o(stall_o), .btn_i(btn_i), .uart_tx_o(uart_tx_o),
        .src_req_o(src_req), .src_ack_i(src_ack)
    );

    // only mei and mti are wired to the core
    always_comb begin
        irq_o     = '0;
        irq_o.mei = mei;
        irq_o.mti = mti;
    end

endmodule

// ==== design/uart_periph.sv ====
`timescale 1ns/1ps
`include "platform_consts.svh"

module uart_periph (
    input  logic                         clk,
    input  logic                         arst_n_i,
    input  logic                         en_i,
    input  bus_pkg::bus_req_t            req_i,
    output logic [31:0]                  rdata_o,
    output logic                         stall_o,
    input  logic                         btn_i,
    output logic                         uart_tx_o,
    output logic [`PLAT_IRQ_SOURCES-1:0] src_req_o,
    input  logic [`PLAT_IRQ_SOURCES-1:0] src_ack_i
);

    localparam int CNT_W = $clog2(`PLAT_UART_CLKS_PER_BIT + 1);
    localparam logic [CNT_W-1:0] LAST_CLK = CNT_W'(`PLAT_UART_CLKS_PER_BIT - 1);
    localparam int BTN_IDX  = int'(periph_pkg::SRC_BUTTON) - 1;
    localparam int DONE_IDX = int'(periph_pkg::SRC_UART_DONE) - 1;

    periph_pkg::uart_state_e state_q;
    logic [CNT_W-1:0]        clk_cnt_q;
    logic [2:0]              bit_idx_q;
    logic [7:0]              shift_q;
    logic                    busy;
    logic                    bit_end;
    logic                    tx_wr;
    logic                    uart_done;
    logic                    btn_meta_q;
    logic                    btn_sync_q;
    logic                    btn_prev_q;
    logic                    btn_rise;
    logic                    btn_seen_q;   // status mirror of the irq lines
    logic                    done_seen_q;

    assign busy      = (state_q != periph_pkg::UART_IDLE);
    assign bit_end   = (clk_cnt_q == LAST_CLK);
    assign tx_wr     = en_i && (|req_i.we) && (req_i.addr[3:2] == 2'd0);
    assign stall_o   = tx_wr && busy;  // hold the core until the frame is out
    assign uart_done = (state_q == periph_pkg::UART_STOP) && bit_end;

    //////////////////////////////////////////////////
    // transmitter
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= periph_pkg::UART_IDLE;
            clk_cnt_q <= '0;
            bit_idx_q <= '0;
        end else begin
            clk_cnt_q <= (!busy || bit_end) ? '0 : clk_cnt_q + 1'b1;
            case (state_q)
                periph_pkg::UART_IDLE:  if (tx_wr) state_q <= periph_pkg::UART_START;
                periph_pkg::UART_START: if (bit_end) begin
                    state_q   <= periph_pkg::UART_DATA;
                    bit_idx_q <= '0;
                end
                periph_pkg::UART_DATA:  if (bit_end) begin
                    bit_idx_q <= bit_idx_q + 3'd1;
                    if (bit_idx_q == 3'd7) state_q <= periph_pkg::UART_STOP;
                end
                default:                if (bit_end) state_q <= periph_pkg::UART_IDLE;
            endcase
        end
    end

    // payload, lsb goes out first
    always_ff @(posedge clk) begin
        if (tx_wr && !busy) begin
            shift_q <= req_i.wdata[7:0];
        end else if (state_q == periph_pkg::UART_DATA && bit_end) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    always_comb begin
        case (state_q)
            periph_pkg::UART_START: uart_tx_o = 1'b0;
            periph_pkg::UART_DATA:  uart_tx_o = shift_q[0];
            default:                uart_tx_o = 1'b1;  // idle and stop
        endcase
    end

    //////////////////////////////////////////////////
    // button sync, edge detect, status
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            btn_meta_q  <= 1'b0;
            btn_sync_q  <= 1'b0;
            btn_prev_q  <= 1'b0;
            btn_seen_q  <= 1'b0;
            done_seen_q <= 1'b0;
        end else begin
            btn_meta_q  <= btn_i;
            btn_sync_q  <= btn_meta_q;
            btn_prev_q  <= btn_sync_q;
            btn_seen_q  <= btn_rise | (btn_seen_q & ~src_ack_i[BTN_IDX]);
            done_seen_q <= uart_done | (done_seen_q & ~src_ack_i[DONE_IDX]);
        end
    end

    assign btn_rise = btn_sync_q & ~btn_prev_q;

    always_comb begin
        src_req_o           = '0;
        src_req_o[BTN_IDX]  = btn_rise;
        src_req_o[DONE_IDX] = uart_done;
    end

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (req_i.addr[3:2] == 2'd1) begin
                rdata_o <= {28'd0, done_seen_q, btn_seen_q, btn_sync_q, busy};
            end else begin
                rdata_o <= '0;  // tx data is write only
            end
        end
    end

endmodule

// ==== design/plic.sv ====
`timescale 1ns/1ps
`include "platform_consts.svh"

module plic (
    input  logic                         clk,
    input  logic                         arst_n_i,
    input  logic                         en_i,
    input  bus_pkg::bus_req_t            req_i,
    output logic [31:0]                  rdata_o,
    input  logic [`PLAT_IRQ_SOURCES-1:0] src_req_i,   // bit i is source id i+1
    output logic [`PLAT_IRQ_SOURCES-1:0] src_ack_o,
    output logic                         mei_o
);

    localparam int N = `PLAT_IRQ_SOURCES;

    logic [N-1:0]         pending_q;
    logic [N-1:0]         enable_q;
    logic [N-1:0]         active;
    logic [N-1:0]         claim_mask;
    periph_pkg::irq_src_e claim_id;
    logic                 offset;     // 0 enable mask, 1 claim
    logic                 claim_rd;
    logic                 mask_wr;

    assign offset   = req_i.addr[2];
    assign claim_rd = en_i && (req_i.we == 4'b0000) && offset;
    assign mask_wr  = en_i && req_i.we[0] && !offset;
    assign active   = pending_q & enable_q;

    //////////////////////////////////////////////////
    // fixed priority, lowest id first
    //////////////////////////////////////////////////

    always_comb begin
        claim_id   = periph_pkg::SRC_NONE;
        claim_mask = '0;
        // walk down so the lowest hit is the last one kept
        for (int i = N - 1; i >= 0; i--) begin
            if (active[i]) begin
                claim_id      = periph_pkg::irq_src_e'(i + 1);
                claim_mask    = '0;
                claim_mask[i] = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // pending, mask, ack pulses
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pending_q <= '0;
            enable_q  <= '0;
            src_ack_o <= '0;
        end else begin
            // a fresh request on the claim edge stays pending
            if (claim_rd) begin
                pending_q <= (pending_q & ~claim_mask) | src_req_i;
                src_ack_o <= claim_mask;
            end else begin
                pending_q <= pending_q | src_req_i;
                src_ack_o <= '0;
            end
            if (mask_wr) begin
                enable_q <= req_i.wdata[N-1:0];
            end
        end
    end

    assign mei_o = |active;

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (offset) begin
                rdata_o <= {30'd0, claim_id};
            end else begin
                rdata_o <= {{(32-N){1'b0}}, enable_q};
            end
        end
    end

endmodule

// ==== design/machine_timer.sv ====
`timescale 1ns/1ps

module machine_timer (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              en_i,
    input  bus_pkg::bus_req_t req_i,
    output logic [31:0]       rdata_o,
    output logic [63:0]       mtime_o,
    output logic              mti_o
);

    logic [63:0] mtime_q;
    logic [63:0] mtimecmp_q;
    logic [1:0]  offset;
    logic        wr_en;

    assign offset = req_i.addr[3:2];  // 0 mtime lo, 1 hi, 2 cmp lo, 3 cmp hi
    assign wr_en  = en_i && (|req_i.we);

    //////////////////////////////////////////////////
    // counter and compare register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;  // no interrupt out of reset
        end else begin
            mtime_q <= mtime_q + 64'd1;
            if (wr_en) begin
                // mtime itself is read only here
                for (int b = 0; b < 4; b++) begin
                    if (req_i.we[b]) begin
                        if (offset == 2'd2) begin
                            mtimecmp_q[8*b +: 8] <= req_i.wdata[8*b +: 8];
                        end else if (offset == 2'd3) begin
                            mtimecmp_q[32 + 8*b +: 8] <= req_i.wdata[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

    assign mti_o   = (mtime_q >= mtimecmp_q);
    assign mtime_o = mtime_q;

    //////////////////////////////////////////////////
    // read port
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (en_i) begin
            case (offset)
                2'd0:    rdata_o <= mtime_q[31:0];
                2'd1:    rdata_o <= mtime_q[63:32];
                2'd2:    rdata_o <= mtimecmp_q[31:0];
                default: rdata_o <= mtimecmp_q[63:32];
            endcase
        end
    end

endmodule

// ==== design/dual_port_ram.sv ====
`timescale 1ns/1ps
`include "platform_consts.svh"

module dual_port_ram (
    input  logic              clk,
    // instruction side, read only
    input  logic              fetch_en_i,
    input  logic [31:0]       fetch_addr_i,
    output logic [31:0]       fetch_data_o,
    // data side
    input  logic              en_i,
    input  bus_pkg::bus_req_t req_i,
    output logic [31:0]       rdata_o
);

    localparam int ADDR_W = $clog2(`PLAT_RAM_WORDS);

    logic [31:0]       mem [`PLAT_RAM_WORDS];
    logic [ADDR_W-1:0] fetch_idx;
    logic [ADDR_W-1:0] data_idx;

    // byte address in, word index out
    assign fetch_idx = fetch_addr_i[ADDR_W+1:2];
    assign data_idx  = req_i.addr[ADDR_W+1:2];

    //////////////////////////////////////////////////
    // fetch port
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (fetch_en_i) begin  // held while the core is stalled
            fetch_data_o <= mem[fetch_idx];
        end
    end

    //////////////////////////////////////////////////
    // data port, read-first
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (en_i) begin
            for (int b = 0; b < 4; b++) begin
                if (req_i.we[b]) begin
                    mem[data_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
                end
            end
            rdata_o <= mem[data_idx];  // old word on a write
        end
    end

endmodule

// ==== design/bus_decoder.sv ====
`timescale 1ns/1ps
`include "platform_consts.svh"

module bus_decoder (
    input  logic              clk,
    input  logic              arst_n_i,
    input  bus_pkg::bus_req_t req_i,
    output logic              ram_en_o,
    output logic              rtc_en_o,
    output logic              plic_en_o,
    output logic              periph_en_o,
    input  logic [31:0]       ram_rdata_i,
    input  logic [31:0]       rtc_rdata_i,
    input  logic [31:0]       plic_rdata_i,
    input  logic [31:0]       periph_rdata_i,
    output logic [31:0]       rdata_o
);

    bus_pkg::region_e region;
    bus_pkg::region_e sel_q;   // region of the previous request cycle
    logic [3:0]       nib;

    assign nib = req_i.addr[31:28];

    //////////////////////////////////////////////////
    // region selection
    //////////////////////////////////////////////////

    always_comb begin
        if (nib < `PLAT_RTC_BASE_NIB) begin
            region = bus_pkg::REG_RAM;
        end else if (nib < `PLAT_PLIC_BASE_NIB) begin
            region = bus_pkg::REG_RTC;
        end else if (nib < `PLAT_PERIPH_BASE_NIB) begin
            region = bus_pkg::REG_PLIC;
        end else begin
            region = bus_pkg::REG_PERIPH;
        end
    end

    assign ram_en_o    = req_i.en && (region == bus_pkg::REG_RAM);
    assign rtc_en_o    = req_i.en && (region == bus_pkg::REG_RTC);
    assign plic_en_o   = req_i.en && (region == bus_pkg::REG_PLIC);
    assign periph_en_o = req_i.en && (region == bus_pkg::REG_PERIPH);

    //////////////////////////////////////////////////
    // read return, lines up with slave read regs
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sel_q <= bus_pkg::REG_RAM;
        end else begin
            sel_q <= region;
        end
    end

    always_comb begin
        case (sel_q)
            bus_pkg::REG_RTC:    rdata_o = rtc_rdata_i;
            bus_pkg::REG_PLIC:   rdata_o = plic_rdata_i;
            bus_pkg::REG_PERIPH: rdata_o = periph_rdata_i;
            default:             rdata_o = ram_rdata_i;
        endcase
    end

endmodule

// ==== design/periph_pkg.sv ====
`include "platform_consts.svh"

package periph_pkg;

    // interrupt source ids, also the claim value
    // lower id wins
    typedef enum logic [1:0] {
        SRC_NONE      = 2'd0,
        SRC_BUTTON    = 2'd1,
        SRC_UART_DONE = 2'd2
    } irq_src_e;

    // uart transmitter states
    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_e;

    // machine interrupt vector as the core sees it
    typedef struct packed {
        logic [31:`PLAT_MEI_BIT+1]            rsvd_hi;
        logic                                 mei;     // external, from plic
        logic [`PLAT_MEI_BIT-1:`PLAT_MTI_BIT+1] rsvd_mid;
        logic                                 mti;     // timer
        logic [`PLAT_MTI_BIT-1:0]             rsvd_lo;
    } cpu_irq_t;

endpackage

// ==== design/bus_pkg.sv ====
package bus_pkg;

    //////////////////////////////////////////////////
    // data bus request, driven by the requester
    //////////////////////////////////////////////////

    // plain strobes, no handshake
    // read data comes back one cycle after en
    typedef struct packed {
        logic        en;     // access this cycle
        logic [3:0]  we;     // byte enables, zero means read
        logic [31:0] addr;
        logic [31:0] wdata;
    } bus_req_t;

    //////////////////////////////////////////////////
    // address regions
    //////////////////////////////////////////////////

    // picked from addr[31:28]
    typedef enum logic [1:0] {
        REG_RAM    = 2'd0,  // 0x0..0x1
        REG_RTC    = 2'd1,  // 0x2
        REG_PLIC   = 2'd2,  // 0x3..0x7
        REG_PERIPH = 2'd3   // 0x8 and up
    } region_e;

endpackage

// ==== design/platform_consts.svh ====
`ifndef PLATFORM_CONSTS_SVH
`define PLATFORM_CONSTS_SVH

// address map, selected by addr[31:28]
`define PLAT_RTC_BASE_NIB     4'h2  // timer region
`define PLAT_PLIC_BASE_NIB    4'h3  // plic region, up to 0x7
`define PLAT_PERIPH_BASE_NIB  4'h8  // peripherals, everything above

// memory
`define PLAT_RAM_WORDS        1024

// uart bit time in clocks
`define PLAT_UART_CLKS_PER_BIT 4

// interrupts
`define PLAT_IRQ_SOURCES      2
`define PLAT_MEI_BIT          11
`define PLAT_MTI_BIT          7
`endif
